// File: verilog/des_pkg.sv
package des_pkg;

	localparam int block_w = 64;
	localparam int half_w = 32;
	localparam int key_w = 64;
	localparam int cd_w = 56;
	localparam int cd_half_w = 28;
	localparam int subkey_w = 48;
	localparam int num_rounds = 16;
	localparam int round_w = 4;

	// Entry 1 of each table sits in the top slot, shorter tables pad with zeros above.
	localparam logic [63:0][6:0] ip_table = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam logic [63:0][6:0] fp_table = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
	};

	localparam logic [55:0][6:0] pc1_table = '{
		57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
	};

	localparam logic [47:0][6:0] pc2_table = '{
		14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	localparam logic [47:0][6:0] e_table = '{
		32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
	};

	localparam logic [31:0][6:0] p_table = '{
		16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
	};

	localparam logic [0:15][1:0] shift_table = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	// Row major, 16 columns per row.
	localparam logic [0:7][0:63][3:0] sbox_table = '{
		'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
		  0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
		  4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
		  15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
		'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
		  3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
		  0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
		  13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
		'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
		  13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
		  13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
		  1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
		'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
		  13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
		  10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
		  3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
		'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
		  14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
		  4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
		  11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
		'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
		  10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
		  9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
		  4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
		'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
		  13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
		  1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
		  6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
		'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
		  1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
		  7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
		  2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
	};

	typedef enum logic {
		MODE_ENCRYPT = 1'b0,
		MODE_DECRYPT = 1'b1
	} des_mode_t;

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_ROUND = 1'b1
	} ctrl_state_t;

	// Source and result are right aligned; DES bit n of src is src[src_w - n].
	function automatic logic [block_w-1:0] permute(input logic [block_w-1:0] src,
		input int src_w, input logic [63:0][6:0] tbl, input int dst_w);
		logic [block_w-1:0] res;
		res = '0;
		for (int i = 0; i < block_w; i++) begin
			if (i < dst_w) begin
				res[i] = src[src_w - tbl[i]];
			end
		end
		return res;
	endfunction

endpackage

// File: verilog/des_control.sv
`timescale 1ns/1ps

module des_control (
	input logic clk,
	input logic rst_n,
	input logic start,
	output logic load,
	output logic round_en,
	output logic finish,
	output logic [des_pkg::round_w-1:0] round,
	output logic oflag
);

	des_pkg::ctrl_state_t state;

	assign load = (state == des_pkg::ST_IDLE) && start; // Accepting cycle.
	assign round_en = (state == des_pkg::ST_ROUND);
	assign finish = round_en && (round == des_pkg::round_w'(des_pkg::num_rounds - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= des_pkg::ST_IDLE;
			round <= '0;
			oflag <= 1'b0;
		end else begin
			oflag <= finish; // One cycle done pulse.
			case (state)
				des_pkg::ST_IDLE: begin
					if (start) begin
						state <= des_pkg::ST_ROUND;
						round <= '0;
					end
				end
				des_pkg::ST_ROUND: begin
					round <= round + 1'b1;
					if (finish) begin
						state <= des_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= des_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: verilog/des_key_schedule.sv
`timescale 1ns/1ps

module des_key_schedule (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic round_en,
	input logic mode,
	input logic [des_pkg::key_w-1:0] key,
	input logic [des_pkg::round_w-1:0] round,
	output logic [des_pkg::subkey_w-1:0] subkey
);

	des_pkg::des_mode_t mode_q;
	logic [des_pkg::cd_w-1:0] cd_q;
	logic [des_pkg::cd_w-1:0] cd_next;
	logic [des_pkg::cd_half_w-1:0] c_rot;
	logic [des_pkg::cd_half_w-1:0] d_rot;
	logic [4:0] rot_r;

	// Every rotation done as a right rotate of the doubled half.
	always_comb begin
		if (mode_q == des_pkg::MODE_ENCRYPT) begin
			rot_r = 5'(des_pkg::cd_half_w - des_pkg::shift_table[round]);
		end else if (round == '0) begin
			rot_r = '0; // K16 comes straight from PC-1.
		end else begin
			rot_r = 5'(des_pkg::shift_table[des_pkg::num_rounds - round]);
		end
	end

	assign c_rot = des_pkg::cd_half_w'({cd_q[des_pkg::cd_w-1 -: des_pkg::cd_half_w],
		cd_q[des_pkg::cd_w-1 -: des_pkg::cd_half_w]} >> rot_r);
	assign d_rot = des_pkg::cd_half_w'({cd_q[des_pkg::cd_half_w-1:0],
		cd_q[des_pkg::cd_half_w-1:0]} >> rot_r);
	assign cd_next = {c_rot, d_rot};

	assign subkey = des_pkg::subkey_w'(des_pkg::permute(cd_next, des_pkg::cd_w,
		des_pkg::pc2_table, des_pkg::subkey_w));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mode_q <= des_pkg::MODE_ENCRYPT;
		end else if (load) begin
			mode_q <= des_pkg::des_mode_t'(mode);
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			cd_q <= des_pkg::cd_w'(des_pkg::permute(key, des_pkg::key_w,
				des_pkg::pc1_table, des_pkg::cd_w)); // Parity bits dropped.
		end else if (round_en) begin
			cd_q <= cd_next;
		end
	end

endmodule

// File: verilog/des_feistel.sv
`timescale 1ns/1ps

module des_feistel (
	input logic [des_pkg::half_w-1:0] r_half,
	input logic [des_pkg::subkey_w-1:0] subkey,
	output logic [des_pkg::half_w-1:0] f_out
);

	logic [des_pkg::subkey_w-1:0] e_xor;
	logic [des_pkg::half_w-1:0] sb_out;

	assign e_xor = subkey ^ des_pkg::subkey_w'(des_pkg::permute(r_half, des_pkg::half_w,
		des_pkg::e_table, des_pkg::subkey_w));

	always_comb begin
		logic [5:0] grp;
		grp = '0;
		sb_out = '0;
		for (int s = 0; s < 8; s++) begin
			grp = e_xor[des_pkg::subkey_w-1 - 6*s -: 6];
			// Row from the outer bits, column from the inner four.
			sb_out[des_pkg::half_w-1 - 4*s -: 4] =
				des_pkg::sbox_table[s][{grp[5], grp[0], grp[4:1]}];
		end
	end

	assign f_out = des_pkg::half_w'(des_pkg::permute(sb_out, des_pkg::half_w,
		des_pkg::p_table, des_pkg::half_w));

endmodule

// File: verilog/des_datapath.sv
`timescale 1ns/1ps

module des_datapath (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic round_en,
	input logic finish,
	input logic [des_pkg::block_w-1:0] din,
	input logic [des_pkg::subkey_w-1:0] subkey,
	output logic [des_pkg::block_w-1:0] dout
);

	logic [des_pkg::half_w-1:0] l_q;
	logic [des_pkg::half_w-1:0] r_q;
	logic [des_pkg::half_w-1:0] r_new;
	logic [des_pkg::half_w-1:0] f_out;
	logic [des_pkg::block_w-1:0] ip_din;

	des_feistel feistel_inst (
		.r_half(r_q),
		.subkey(subkey),
		.f_out(f_out)
	);

	assign ip_din = des_pkg::permute(din, des_pkg::block_w, des_pkg::ip_table,
		des_pkg::block_w);
	assign r_new = l_q ^ f_out;

	always_ff @(posedge clk) begin
		if (load) begin
			{l_q, r_q} <= ip_din;
		end else if (round_en) begin
			l_q <= r_q;
			r_q <= r_new;
		end
	end

	// Last round result goes out swapped as R16 L16.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dout <= '0;
		end else if (finish) begin
			dout <= des_pkg::permute({r_new, r_q}, des_pkg::block_w, des_pkg::fp_table,
				des_pkg::block_w);
		end
	end

endmodule

// File: verilog/des.sv
`timescale 1ns/1ps

module des (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic mode,
	input logic [des_pkg::block_w-1:0] din,
	input logic [des_pkg::key_w-1:0] key,
	output logic [des_pkg::block_w-1:0] dout,
	output logic oflag
);

	logic load;
	logic round_en;
	logic finish;
	logic [des_pkg::round_w-1:0] round;
	logic [des_pkg::subkey_w-1:0] subkey;

	des_control control_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.load(load),
		.round_en(round_en),
		.finish(finish),
		.round(round),
		.oflag(oflag)
	);

	des_key_schedule key_schedule_inst (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.round_en(round_en),
		.mode(mode),
		.key(key),
		.round(round),
		.subkey(subkey)
	);

	des_datapath datapath_inst (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.round_en(round_en),
		.finish(finish),
		.din(din),
		.subkey(subkey),
		.dout(dout)
	);

endmodule

// File: testbench/des_tb.sv
`timescale 1ns/1ps

module des_tb;

	localparam int latency = 17; // Edges from driving start to oflag rising.
	localparam int timeout_cycles = 40;
	localparam int hold_cycles = 5;
	localparam int quiet_cycles = 20;
	localparam int busy_edge = 5;
	localparam int num_trips = 20;
	localparam int num_vectors = 6;

	// Known answers. The last three rows decrypt the first three.
	localparam logic [0:num_vectors-1] vec_mode = 6'b000111;
	localparam logic [0:num_vectors-1][63:0] vec_key = {
		64'h1334_5779_9BBC_DFF1, 64'h0E32_9232_EA6D_0D73, 64'h0000_0000_0000_0000,
		64'h1334_5779_9BBC_DFF1, 64'h0E32_9232_EA6D_0D73, 64'h0000_0000_0000_0000
	};
	localparam logic [0:num_vectors-1][63:0] vec_in = {
		64'h0123_4567_89AB_CDEF, 64'h8787_8787_8787_8787, 64'h0000_0000_0000_0000,
		64'h85E8_1354_0F0A_B405, 64'h0000_0000_0000_0000, 64'h8CA6_4DE9_C1B1_23A7
	};
	localparam logic [0:num_vectors-1][63:0] vec_out = {
		64'h85E8_1354_0F0A_B405, 64'h0000_0000_0000_0000, 64'h8CA6_4DE9_C1B1_23A7,
		64'h0123_4567_89AB_CDEF, 64'h8787_8787_8787_8787, 64'h0000_0000_0000_0000
	};

	logic clk;
	logic rst_n;
	logic start;
	logic mode;
	logic [63:0] din;
	logic [63:0] key;
	logic [63:0] dout;
	logic oflag;
	logic [31:0] lfsr_state;

	des des_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.mode(mode),
		.din(din),
		.key(key),
		.dout(dout),
		.oflag(oflag)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Stopping at first error.");
		end
	endtask

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_word(output logic [63:0] word);
		word = '0;
		for (int i = 0; i < 64; i++) begin
			word = {word[62:0], lfsr_state[31]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// No done pulse and a steady output for a number of cycles.
	task automatic expect_quiet(input int cycles, input logic [63:0] held);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_value("oflag", 64'(oflag), 64'd0);
			check_value("dout", dout, held);
		end
	endtask

	// A nonzero busy_at strobes start again with other data during the run.
	task automatic run_block(input logic blk_mode, input logic [63:0] blk_key,
		input logic [63:0] blk_din, input int busy_at, output logic [63:0] result);
		int edges;
		logic seen;
		edges = 0;
		seen = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		mode <= blk_mode;
		key <= blk_key;
		din <= blk_din;
		while (!seen && edges < timeout_cycles) begin
			@(posedge clk);
			edges++;
			if (edges == busy_at) begin
				start <= 1'b1;
				mode <= ~blk_mode;
				key <= ~blk_key;
				din <= ~blk_din;
			end else begin
				start <= 1'b0;
			end
			@(negedge clk);
			seen = oflag;
		end
		if (!seen) begin
			$display("Timeout: no done pulse within %0d cycles of start.", timeout_cycles);
			$display("STATUS: FAIL");
			$fatal(1, "Stopping on timeout.");
		end
		check_value("oflag latency", 64'(edges), 64'(latency));
		result = dout;
		expect_quiet(hold_cycles, result); // Pulse lasts one cycle.
	endtask

	initial begin
		logic [63:0] result;
		logic [63:0] trip_key;
		logic [63:0] trip_block;
		logic [63:0] cipher;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		mode = 1'b0;
		din = '0;
		key = '0;
		lfsr_state = 32'h31c7_3e39;

		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_value("oflag", 64'(oflag), 64'd0);
			check_value("dout", dout, 64'd0);
		end
		@(posedge clk);
		rst_n <= 1'b1;
		expect_quiet(3, 64'd0); // Still zero before the first start.

		for (int i = 0; i < num_vectors; i++) begin
			run_block(vec_mode[i], vec_key[i], vec_in[i], 0, result);
			check_value("dout", result, vec_out[i]);
		end

		// Decrypting the ciphertext must give back the block.
		for (int i = 0; i < num_trips; i++) begin
			draw_word(trip_key);
			draw_word(trip_block);
			run_block(1'b0, trip_key, trip_block, 0, cipher);
			run_block(1'b1, trip_key, cipher, 0, result);
			check_value("dout", result, trip_block);
		end

		run_block(vec_mode[0], vec_key[0], vec_in[0], busy_edge, result);
		check_value("dout", result, vec_out[0]);
		expect_quiet(quiet_cycles, result); // Busy start left no run behind.

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: sim.f
verilog/des_pkg.sv
verilog/des_control.sv
verilog/des_key_schedule.sv
verilog/des_feistel.sv
verilog/des_datapath.sv
verilog/des.sv
testbench/des_tb.sv
